// File: rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define RV32I_PC_RESET   32'h0000_0000  // first fetch address after reset
`define RV32I_NREGS      32             // base integer registers incl x0
`define RV32I_NOP        32'h0000_0013  // addi x0, x0, 0 used as bubble

// major opcodes kept by this core
`define RV32I_OPC_OP     7'b0110011
`define RV32I_OPC_OP_IMM 7'b0010011
`define RV32I_OPC_LUI    7'b0110111
`define RV32I_OPC_BRANCH 7'b1100011
`define RV32I_OPC_LOAD   7'b0000011
`define RV32I_OPC_STORE  7'b0100011

`define RV32I_F3_ADD     3'b000  // add/sub, addi
`define RV32I_F3_SLL     3'b001
`define RV32I_F3_SLT     3'b010
`define RV32I_F3_SLTU    3'b011
`define RV32I_F3_XOR     3'b100
`define RV32I_F3_SR      3'b101  // srl/sra by funct7 bit 5
`define RV32I_F3_OR      3'b110
`define RV32I_F3_AND     3'b111
`define RV32I_F3_WORD    3'b010  // lw and sw, the only width kept

`define RV32I_F3_BEQ     3'b000
`define RV32I_F3_BNE     3'b001
`define RV32I_F3_BLT     3'b100
`define RV32I_F3_BGE     3'b101
`define RV32I_F3_BLTU    3'b110
`define RV32I_F3_BGEU    3'b111

`endif

// File: rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  typedef logic [31:0] word_t;      // data value or byte address
  typedef logic [31:0] inst_t;      // raw instruction word
  typedef logic [4:0]  reg_addr_t;  // x0..x31
  typedef logic [2:0]  funct3_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  typedef enum logic [2:0] {
    cls_nop,     // unsupported encodings end up here too
    cls_alu,     // op and op-imm
    cls_lui,
    cls_branch,
    cls_load,
    cls_store
  } op_class_e;

  typedef enum logic [1:0] {
    mem_idle,
    mem_wait_ack,  // cyc held, waiting for the data ack
    mem_done       // one quiet bus cycle after each access
  } mem_state_e;

endpackage

`default_nettype wire

// File: rv32i_stage_ifs.sv
`default_nettype none

interface fetch_decode_if import rv32i_pkg::*; ();
  logic  valid;  // slot holds an acknowledged instruction
  word_t pc;
  inst_t inst;   // nop word when the slot is a bubble

  modport producer (output valid, pc, inst);
  modport consumer (input valid, pc, inst);
endinterface

interface decode_execute_if import rv32i_pkg::*; ();
  logic      valid;
  word_t     pc;        // branch base
  op_class_e op_class;
  alu_op_e   alu_op;
  funct3_t   funct3;    // branch condition
  reg_addr_t rs1_addr;  // zero when the operand is unused
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_we;     // never set for x0
  word_t     imm;       // already sign extended and shifted
  logic      use_imm;   // imm replaces rs2 as alu operand b

  modport producer (
    output valid, pc, op_class, alu_op, funct3, rs1_addr, rs2_addr,
           rd_addr, rd_we, imm, use_imm
  );
  modport consumer (
    input valid, pc, op_class, alu_op, funct3, rs1_addr, rs2_addr,
          rd_addr, rd_we, imm, use_imm
  );
endinterface

interface execute_memory_if import rv32i_pkg::*; ();
  logic      valid;
  op_class_e op_class;
  reg_addr_t rd_addr;
  logic      rd_we;
  word_t     result;      // alu value or load/store address
  word_t     store_data;  // forwarded rs2

  modport producer (output valid, op_class, rd_addr, rd_we, result, store_data);
  modport consumer (input valid, op_class, rd_addr, rd_we, result, store_data);
endinterface

`default_nettype wire

// File: rv32i_fetch.sv
`default_nettype none
`include "rv32i_consts.svh"

module rv32i_fetch import rv32i_pkg::*; (
  input  wire logic           i_clk,
  input  wire logic           i_arst_n,
  input  wire logic           i_stall,        // load-use or data bus busy
  input  wire logic           i_redirect,     // taken branch in execute
  input  wire word_t          i_redirect_pc,
  output word_t               o_iaddr,
  output logic                o_stb_inst,
  input  wire logic           i_ack_inst,
  input  wire inst_t          i_inst,
  fetch_decode_if.producer    o_fd
);

  word_t pc;
  logic  take;  // acked word that survives a redirect

  assign o_iaddr    = pc;
  assign o_stb_inst = !i_stall;  // ask only when the slot can move
  assign take       = i_ack_inst && !i_redirect;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc         <= `RV32I_PC_RESET;
      o_fd.valid <= 1'b0;
    end else if (!i_stall) begin
      o_fd.valid <= take;  // no ack gives a bubble
      if (i_redirect) begin
        pc <= i_redirect_pc;  // word in flight is dropped
      end else if (i_ack_inst) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_fd.pc   <= pc;
      o_fd.inst <= take ? i_inst : `RV32I_NOP;
    end
  end

endmodule

`default_nettype wire

// File: rv32i_regfile.sv
`default_nettype none
`include "rv32i_consts.svh"

module rv32i_regfile import rv32i_pkg::*; (
  input  wire logic      i_clk,
  input  wire logic      i_rd_en,     // read strobe, low while execute is frozen
  input  wire reg_addr_t i_rs1_addr,
  input  wire reg_addr_t i_rs2_addr,
  input  wire logic      i_we,
  input  wire reg_addr_t i_wr_addr,
  input  wire word_t     i_wr_data,
  output word_t          o_rs1_data,  // valid in the execute cycle
  output word_t          o_rs2_data
);

  word_t regs [1:`RV32I_NREGS-1];  // x0 has no storage

  // x0 reads zero, a same-cycle write is passed through
  function automatic word_t read_reg(reg_addr_t a);
    if (a == '0) return '0;
    if (i_we && a == i_wr_addr) return i_wr_data;
    return regs[a];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_we && i_wr_addr != '0) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rs1_data <= read_reg(i_rs1_addr);
      o_rs2_data <= read_reg(i_rs2_addr);
    end
  end

endmodule

`default_nettype wire

// File: rv32i_decode.sv
`default_nettype none
`include "rv32i_consts.svh"

module rv32i_decode import rv32i_pkg::*; (
  input  wire logic           i_clk,
  input  wire logic           i_arst_n,
  input  wire logic           i_stall,
  input  wire logic           i_flush,     // taken branch kills this slot
  fetch_decode_if.consumer    i_fd,
  decode_execute_if.producer  o_de,
  output reg_addr_t           o_rs1_addr,  // regfile read addresses
  output reg_addr_t           o_rs2_addr
);

  inst_t     inst;
  logic [6:0] opcode;
  funct3_t   f3;
  reg_addr_t rd;
  logic      f7_zero, f7_alt;  // funct7 is 0000000 or 0100000
  word_t     imm_i, imm_s, imm_b, imm_u;
  op_class_e cls;
  alu_op_e   alu_op;
  word_t     imm;
  logic      use_imm, use_rs1, use_rs2, rd_we;

  function automatic alu_op_e alu_from_f3(funct3_t f, logic alt);
    alu_op_e op;
    case (f)
      `RV32I_F3_ADD:  op = alt ? alu_sub : alu_add;
      `RV32I_F3_SLL:  op = alu_sll;
      `RV32I_F3_SLT:  op = alu_slt;
      `RV32I_F3_SLTU: op = alu_sltu;
      `RV32I_F3_XOR:  op = alu_xor;
      `RV32I_F3_SR:   op = alt ? alu_sra : alu_srl;
      `RV32I_F3_OR:   op = alu_or;
      `RV32I_F3_AND:  op = alu_and;
      default:        op = alu_add;
    endcase
    return op;
  endfunction

  assign inst    = i_fd.inst;
  assign opcode  = inst[6:0];
  assign f3      = inst[14:12];
  assign rd      = inst[11:7];
  assign f7_zero = inst[31:25] == 7'b0000000;
  assign f7_alt  = inst[31:25] == 7'b0100000;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    cls     = cls_nop;  // anything unmatched stays a nop
    alu_op  = alu_add;  // loads and stores add rs1 + imm
    imm     = imm_i;
    use_imm = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      `RV32I_OPC_OP: begin
        if (f7_zero || (f7_alt && (f3 == `RV32I_F3_ADD || f3 == `RV32I_F3_SR))) begin
          cls     = cls_alu;
          alu_op  = alu_from_f3(f3, f7_alt);
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      `RV32I_OPC_OP_IMM: begin
        // shift immediates need a clean funct7, the rest take any upper bits
        if ((f3 != `RV32I_F3_SLL && f3 != `RV32I_F3_SR) || f7_zero ||
            (f7_alt && f3 == `RV32I_F3_SR)) begin
          cls     = cls_alu;
          alu_op  = alu_from_f3(f3, f7_alt && f3 == `RV32I_F3_SR);  // no subi
          use_imm = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      `RV32I_OPC_LUI: begin
        cls = cls_lui;
        imm = imm_u;
      end
      `RV32I_OPC_BRANCH: begin
        if (f3 inside {`RV32I_F3_BEQ, `RV32I_F3_BNE, `RV32I_F3_BLT,
                       `RV32I_F3_BGE, `RV32I_F3_BLTU, `RV32I_F3_BGEU}) begin
          cls     = cls_branch;
          imm     = imm_b;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      `RV32I_OPC_LOAD: begin
        if (f3 == `RV32I_F3_WORD) begin
          cls     = cls_load;
          use_imm = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      `RV32I_OPC_STORE: begin
        if (f3 == `RV32I_F3_WORD) begin
          cls     = cls_store;
          imm     = imm_s;
          use_imm = 1'b1;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign rd_we = (cls == cls_alu || cls == cls_lui || cls == cls_load) && rd != '0;

  // a held slot keeps reading its own sources so late writebacks are caught
  assign o_rs1_addr = i_stall ? o_de.rs1_addr : (use_rs1 ? inst[19:15] : '0);
  assign o_rs2_addr = i_stall ? o_de.rs2_addr : (use_rs2 ? inst[24:20] : '0);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_de.valid <= 1'b0;
    end else if (i_flush) begin
      o_de.valid <= 1'b0;
    end else if (!i_stall) begin
      o_de.valid <= i_fd.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_de.pc       <= i_fd.pc;
      o_de.op_class <= cls;
      o_de.alu_op   <= alu_op;
      o_de.funct3   <= f3;
      o_de.rs1_addr <= o_rs1_addr;  // field value while not stalled
      o_de.rs2_addr <= o_rs2_addr;
      o_de.rd_addr  <= rd;
      o_de.rd_we    <= rd_we;
      o_de.imm      <= imm;
      o_de.use_imm  <= use_imm;
    end
  end

endmodule

`default_nettype wire

// File: rv32i_execute.sv
`default_nettype none
`include "rv32i_consts.svh"

module rv32i_execute import rv32i_pkg::*; (
  input  wire logic           i_clk,
  input  wire logic           i_arst_n,
  input  wire logic           i_stall,          // data bus busy
  decode_execute_if.consumer  i_de,
  input  wire word_t          i_rs1_data,
  input  wire word_t          i_rs2_data,
  execute_memory_if.producer  o_em,
  input  wire logic           i_wb_we,
  input  wire reg_addr_t      i_wb_rd_addr,
  input  wire word_t          i_wb_data,
  output logic                o_redirect,       // one-cycle pulse
  output word_t               o_redirect_pc,
  output logic                o_load_use_stall
);

  word_t rs1_val, rs2_val, op_b, alu_y;
  logic  fwd_mem;       // memory slot result is usable now
  logic  eq, lt_s, lt_u;
  logic  taken;

  // newest value first, a load in memory has no data yet
  function automatic word_t pick(reg_addr_t a, word_t rf_data);
    if (fwd_mem && o_em.rd_addr == a) return o_em.result;
    if (i_wb_we && i_wb_rd_addr == a) return i_wb_data;
    return rf_data;
  endfunction

  assign fwd_mem = o_em.valid && o_em.rd_we && o_em.op_class != cls_load;

  always_comb begin
    rs1_val = pick(i_de.rs1_addr, i_rs1_data);
    rs2_val = pick(i_de.rs2_addr, i_rs2_data);
  end

  assign op_b = i_de.use_imm ? i_de.imm : rs2_val;

  always_comb begin
    case (i_de.alu_op)
      alu_sub:  alu_y = rs1_val - op_b;
      alu_slt:  alu_y = {31'b0, $signed(rs1_val) < $signed(op_b)};
      alu_sltu: alu_y = {31'b0, rs1_val < op_b};
      alu_xor:  alu_y = rs1_val ^ op_b;
      alu_or:   alu_y = rs1_val | op_b;
      alu_and:  alu_y = rs1_val & op_b;
      alu_sll:  alu_y = rs1_val << op_b[4:0];
      alu_srl:  alu_y = rs1_val >> op_b[4:0];
      alu_sra:  alu_y = $signed(rs1_val) >>> op_b[4:0];
      default:  alu_y = rs1_val + op_b;  // add, also load/store address
    endcase
  end

  assign eq   = rs1_val == rs2_val;
  assign lt_s = $signed(rs1_val) < $signed(rs2_val);
  assign lt_u = rs1_val < rs2_val;

  always_comb begin
    case (i_de.funct3)
      `RV32I_F3_BEQ:  taken = eq;
      `RV32I_F3_BNE:  taken = !eq;
      `RV32I_F3_BLT:  taken = lt_s;
      `RV32I_F3_BGE:  taken = !lt_s;
      `RV32I_F3_BLTU: taken = lt_u;
      `RV32I_F3_BGEU: taken = !lt_u;
      default:        taken = 1'b0;
    endcase
  end

  // unused sources carry x0 and rd_we is never set for x0
  assign o_load_use_stall = i_de.valid && o_em.valid && o_em.op_class == cls_load &&
                            o_em.rd_we && (o_em.rd_addr == i_de.rs1_addr ||
                                           o_em.rd_addr == i_de.rs2_addr);

  // wait until operands are final and the slot really moves
  assign o_redirect = i_de.valid && i_de.op_class == cls_branch && taken &&
                      !i_stall && !o_load_use_stall;
  assign o_redirect_pc = i_de.pc + i_de.imm;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_em.valid <= 1'b0;
    end else if (!i_stall) begin
      o_em.valid <= i_de.valid && !o_load_use_stall;  // bubble on load-use
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_em.op_class   <= i_de.op_class;
      o_em.rd_addr    <= i_de.rd_addr;
      o_em.rd_we      <= i_de.rd_we;
      o_em.result     <= (i_de.op_class == cls_lui) ? i_de.imm : alu_y;
      o_em.store_data <= rs2_val;
    end
  end

endmodule

`default_nettype wire

// File: rv32i_memory.sv
`default_nettype none

module rv32i_memory import rv32i_pkg::*; (
  input  wire logic           i_clk,
  input  wire logic           i_arst_n,
  execute_memory_if.consumer  i_em,
  output logic                o_wb_cyc_data,
  output logic                o_wb_stb_data,
  output logic                o_wb_we_data,
  output word_t               o_wb_addr_data,
  output word_t               o_wb_data_data,
  input  wire logic           i_wb_ack_data,
  input  wire word_t          i_wb_data_data,
  output logic                o_busy,        // holds every earlier stage
  output logic                o_wb_we,
  output reg_addr_t           o_wb_rd_addr,
  output word_t               o_wb_data
);

  mem_state_e state;
  logic       is_load;
  logic       mem_op;   // slot needs a bus cycle
  logic       ack_now;

  assign is_load = i_em.op_class == cls_load;
  assign mem_op  = i_em.valid && (is_load || i_em.op_class == cls_store);
  assign ack_now = state == mem_wait_ack && i_wb_ack_data;
  assign o_busy  = mem_op && !ack_now;  // released in the ack cycle

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state         <= mem_idle;
      o_wb_cyc_data <= 1'b0;
      o_wb_stb_data <= 1'b0;
    end else begin
      o_wb_stb_data <= 1'b0;  // strobe lasts a single cycle
      case (state)
        mem_idle: begin
          if (mem_op) begin
            state         <= mem_wait_ack;
            o_wb_cyc_data <= 1'b1;
            o_wb_stb_data <= 1'b1;
          end
        end
        mem_wait_ack: begin
          if (i_wb_ack_data) begin
            state         <= mem_done;
            o_wb_cyc_data <= 1'b0;
          end
        end
        default: state <= mem_idle;  // done, next slot starts from idle
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == mem_idle && mem_op) begin
      o_wb_we_data   <= !is_load;
      o_wb_addr_data <= i_em.result;  // word address from execute
      o_wb_data_data <= i_em.store_data;
    end
  end

  // writeback register, kept steady while the bus is busy
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_we <= 1'b0;
    end else if (!o_busy) begin
      o_wb_we <= i_em.valid && i_em.rd_we;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!o_busy) begin
      o_wb_rd_addr <= i_em.rd_addr;
      o_wb_data    <= is_load ? i_wb_data_data : i_em.result;  // load word rides the ack
    end
  end

endmodule

`default_nettype wire

// File: rv32i_core.sv
`default_nettype none

module rv32i_core import rv32i_pkg::*; (
  input  wire logic  i_clk,
  input  wire logic  i_arst_n,
  input  wire inst_t i_inst,          // instruction port
  output word_t      o_iaddr,
  output logic       o_stb_inst,
  input  wire logic  i_ack_inst,
  output logic       o_wb_cyc_data,   // data port
  output logic       o_wb_stb_data,
  output logic       o_wb_we_data,
  output word_t      o_wb_addr_data,
  output word_t      o_wb_data_data,
  input  wire logic  i_wb_ack_data,
  input  wire word_t i_wb_data_data
);

  fetch_decode_if   fd_if ();
  decode_execute_if de_if ();
  execute_memory_if em_if ();

  reg_addr_t rs1_addr, rs2_addr, wb_rd_addr;
  word_t     rs1_data, rs2_data, wb_data, redirect_pc;
  logic      redirect, mem_busy, load_use_stall, wb_we;
  logic      stall_front;  // fetch and decode hold

  assign stall_front = mem_busy || load_use_stall;

  rv32i_fetch u_fetch (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_stall       (stall_front),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_iaddr       (o_iaddr),
    .o_stb_inst    (o_stb_inst),
    .i_ack_inst    (i_ack_inst),
    .i_inst        (i_inst),
    .o_fd          (fd_if.producer)
  );

  rv32i_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rd_en    (!mem_busy),  // load-use still rereads for the held slot
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_we       (wb_we),
    .i_wr_addr  (wb_rd_addr),
    .i_wr_data  (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv32i_decode u_decode (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_stall    (stall_front),
    .i_flush    (redirect),  // younger slot behind a taken branch
    .i_fd       (fd_if.consumer),
    .o_de       (de_if.producer),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr)
  );

  rv32i_execute u_execute (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_stall          (mem_busy),
    .i_de             (de_if.consumer),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .o_em             (em_if.producer),
    .i_wb_we          (wb_we),
    .i_wb_rd_addr     (wb_rd_addr),
    .i_wb_data        (wb_data),
    .o_redirect       (redirect),
    .o_redirect_pc    (redirect_pc),
    .o_load_use_stall (load_use_stall)
  );

  rv32i_memory u_memory (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_em           (em_if.consumer),
    .o_wb_cyc_data  (o_wb_cyc_data),
    .o_wb_stb_data  (o_wb_stb_data),
    .o_wb_we_data   (o_wb_we_data),
    .o_wb_addr_data (o_wb_addr_data),
    .o_wb_data_data (o_wb_data_data),
    .i_wb_ack_data  (i_wb_ack_data),
    .i_wb_data_data (i_wb_data_data),
    .o_busy         (mem_busy),
    .o_wb_we        (wb_we),
    .o_wb_rd_addr   (wb_rd_addr),
    .o_wb_data      (wb_data)
  );

endmodule

`default_nettype wire

// File: tb_rv32i_core.sv
`default_nettype none
`include "rv32i_consts.svh"

module tb_rv32i_core import rv32i_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles    = 5;
  localparam int body_len        = 60;      // random instructions between prologue and dump
  localparam int mem_words       = 256;     // 1 KiB in each memory
  localparam int data_base       = 'h100;   // 16-word load/store window
  localparam int dump_base       = 'h200;   // x1..x31 land here at the end
  localparam int max_steps       = 4096;
  localparam int cycles_per_inst = 40;

  logic  i_clk;
  logic  i_arst_n;
  inst_t i_inst;
  word_t o_iaddr;
  logic  o_stb_inst;
  logic  i_ack_inst;
  logic  o_wb_cyc_data;
  logic  o_wb_stb_data;
  logic  o_wb_we_data;
  word_t o_wb_addr_data;
  word_t o_wb_data_data;
  logic  i_wb_ack_data;
  word_t i_wb_data_data;

  inst_t imem [mem_words];
  word_t dmem [mem_words];       // live data memory behind the bus
  word_t dmem_init [mem_words];  // same start image for the model
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t obs_addr [$];
  word_t obs_data [$];
  word_t lfsr_state;
  int    prog_len;
  int    n_exp;
  int    n_obs;
  int    n_checked;

  rv32i_core uut (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_inst         (i_inst),
    .o_iaddr        (o_iaddr),
    .o_stb_inst     (o_stb_inst),
    .i_ack_inst     (i_ack_inst),
    .o_wb_cyc_data  (o_wb_cyc_data),
    .o_wb_stb_data  (o_wb_stb_data),
    .o_wb_we_data   (o_wb_we_data),
    .o_wb_addr_data (o_wb_addr_data),
    .o_wb_data_data (o_wb_data_data),
    .i_wb_ack_data  (i_wb_ack_data),
    .i_wb_data_data (i_wb_data_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;  // 100 ns period
  end

  // taps 32 22 2 1
  function automatic word_t lfsr_step(word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t take_bits(int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};  // one step per bit
    end
    return r;
  endfunction

  function automatic int imem_index(word_t pc);
    word_t off;
    off = pc - `RV32I_PC_RESET;
    return int'(off[9:2]);
  endfunction

  function automatic int dmem_index(word_t addr);
    return int'(addr[9:2]);
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV32I_OPC_OP};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, `RV32I_F3_WORD, imm[4:0], `RV32I_OPC_STORE};
  endfunction

  function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV32I_OPC_BRANCH};
  endfunction

  task automatic build_program();
    int        n;
    int        skip;
    int        remain;
    logic [2:0] kind;
    reg_addr_t rd, rs1, rs2, last_rd;
    funct3_t   f3;
    logic      alt;
    logic [11:0] imm12;
    for (int i = 0; i < mem_words; i++) begin
      imem[i]      = `RV32I_NOP;       // fetch runs past the final loop into these
      dmem_init[i] = take_bits(32);
      dmem[i]      = dmem_init[i];
    end
    n = 0;
    for (int r = 1; r < 32; r++) begin
      // dependent addi chain gives every register a defined value
      imem[n] = enc_i(12'(take_bits(12)), reg_addr_t'(r - 1), `RV32I_F3_ADD,
                      reg_addr_t'(r), `RV32I_OPC_OP_IMM);
      n++;
    end
    last_rd = reg_addr_t'(31);
    for (int j = 0; j < body_len; j++) begin
      kind = 3'(take_bits(3));
      rd   = reg_addr_t'(take_bits(5));  // x0 shows up now and then
      rs1  = take_bits(1) ? last_rd : reg_addr_t'(take_bits(5));
      rs2  = reg_addr_t'(take_bits(5));
      f3   = funct3_t'(take_bits(3));
      case (kind)
        3'd0, 3'd1: begin
          alt = (f3 == `RV32I_F3_ADD || f3 == `RV32I_F3_SR) && take_bits(1) != '0;
          imem[n] = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
          last_rd = rd;
        end
        3'd2, 3'd3: begin
          if (f3 == `RV32I_F3_SLL || f3 == `RV32I_F3_SR) begin
            alt   = f3 == `RV32I_F3_SR && take_bits(1) != '0;
            imm12 = {1'b0, alt, 5'b0, 5'(take_bits(5))};  // shamt plus srai flag
          end else begin
            imm12 = 12'(take_bits(12));
          end
          imem[n] = enc_i(imm12, rs1, f3, rd, `RV32I_OPC_OP_IMM);
          last_rd = rd;
        end
        3'd4: begin
          imem[n] = {20'(take_bits(20)), rd, `RV32I_OPC_LUI};
          last_rd = rd;
        end
        3'd5: begin
          imm12   = 12'(data_base + 4 * int'(take_bits(4)));
          imem[n] = enc_i(imm12, '0, `RV32I_F3_WORD, rd, `RV32I_OPC_LOAD);
          last_rd = rd;  // next one often reads it at once
        end
        3'd6: begin
          imm12   = 12'(data_base + 4 * int'(take_bits(4)));
          imem[n] = enc_s(imm12, last_rd, '0);  // store data from the newest result
        end
        default: begin
          if (f3 == 3'b010 || f3 == 3'b011) f3 = {2'b00, f3[0]};  // no such branch
          if (take_bits(1) != '0) rs2 = rs1;    // equal operands get taken more often
          skip   = int'(take_bits(2));
          remain = body_len - 1 - j;
          if (skip > remain) skip = remain;     // only forward and at most to the dump
          imem[n] = enc_b(13'(4 * (skip + 1)), rs2, rs1, f3);
        end
      endcase
      n++;
    end
    for (int r = 1; r < 32; r++) begin
      imem[n] = enc_s(12'(dump_base + 4 * (r - 1)), reg_addr_t'(r), '0);
      n++;
    end
    imem[n] = enc_b('0, '0, '0, `RV32I_F3_BEQ);  // spin here forever
    n++;
    prog_len = n;
  endtask

  function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
    case (f3)
      `RV32I_F3_ADD:  return alt ? a - b : a + b;
      `RV32I_F3_SLL:  return a << b[4:0];
      `RV32I_F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `RV32I_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      `RV32I_F3_XOR:  return a ^ b;
      `RV32I_F3_OR:   return a | b;
      `RV32I_F3_AND:  return a & b;
      default: begin
        if (alt) return $signed(a) >>> b[4:0];  // sra keeps the sign
        return a >> b[4:0];
      end
    endcase
  endfunction

  function automatic logic branch_ref(funct3_t f3, word_t a, word_t b);
    case (f3)
      `RV32I_F3_BEQ:  return a == b;
      `RV32I_F3_BNE:  return a != b;
      `RV32I_F3_BLT:  return $signed(a) < $signed(b);
      `RV32I_F3_BGE:  return $signed(a) >= $signed(b);
      `RV32I_F3_BLTU: return a < b;
      default:        return a >= b;
    endcase
  endfunction

  // instruction-set model that fills the ordered list of expected stores
  function automatic void run_model();
    word_t     x [32];
    word_t     mdm [mem_words];
    word_t     pc, a, b, imm_i, imm_s, imm_b, addr;
    inst_t     inst;
    funct3_t   f3;
    reg_addr_t rd;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < mem_words; i++) mdm[i] = dmem_init[i];
    pc = `RV32I_PC_RESET;
    for (int step = 0; step < max_steps; step++) begin
      inst  = imem[imem_index(pc)];
      f3    = inst[14:12];
      rd    = inst[11:7];
      a     = x[inst[19:15]];
      b     = x[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      if (inst[6:0] == `RV32I_OPC_BRANCH && imm_b == '0 && branch_ref(f3, a, b)) break;
      case (inst[6:0])
        `RV32I_OPC_OP:     x[rd] = alu_ref(f3, inst[30], a, b);
        `RV32I_OPC_OP_IMM: x[rd] = alu_ref(f3, f3 == `RV32I_F3_SR && inst[30], a, imm_i);
        `RV32I_OPC_LUI:    x[rd] = {inst[31:12], 12'b0};
        `RV32I_OPC_LOAD:   x[rd] = mdm[dmem_index(a + imm_i)];
        `RV32I_OPC_STORE: begin
          addr = a + imm_s;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          mdm[dmem_index(addr)] = b;
        end
        default: ;
      endcase
      x[0] = '0;
      if (inst[6:0] == `RV32I_OPC_BRANCH && branch_ref(f3, a, b)) pc = pc + imm_b;
      else pc = pc + 32'd4;
    end
    n_exp = exp_addr.size();
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_failure(string what);
    $display("ERROR time=%0t %s", $time, what);
    abort_run();
  endtask

  task automatic check_word(string name, word_t exp, word_t got);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h observed=%h", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int exp, int got);
    if (got != exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%0d observed=%0d", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b observed=%b", $time, name, exp, got);
      abort_run();
    end
  endtask

  // instruction memory withholds the ack on about one cycle in four
  initial begin
    logic ack;
    @(posedge i_clk);
    forever begin
      @(negedge i_clk);
      ack        = o_stb_inst && take_bits(2) != '0;
      i_ack_inst = ack;
      i_inst     = ack ? imem[imem_index(o_iaddr)] : `RV32I_NOP;
    end
  end

  // data memory answers each strobe after 0 to 3 cycles and checks the bus protocol
  initial begin
    logic  busy, we, ack;
    word_t addr, wdata, rdata;
    int    delay;
    busy = 1'b0;
    @(posedge i_clk);
    forever begin
      @(negedge i_clk);
      ack   = 1'b0;
      rdata = '0;
      if (busy) begin
        check_flag("o_wb_cyc_data", 1'b1, o_wb_cyc_data);  // held until ack
        check_flag("o_wb_stb_data", 1'b0, o_wb_stb_data);  // single-cycle strobe
      end else if (o_wb_stb_data) begin
        check_flag("o_wb_cyc_data", 1'b1, o_wb_cyc_data);
        busy  = 1'b1;
        we    = o_wb_we_data;
        addr  = o_wb_addr_data;
        wdata = o_wb_data_data;
        delay = int'(take_bits(2));
      end else begin
        check_flag("o_wb_cyc_data", 1'b0, o_wb_cyc_data);
      end
      if (busy) begin
        if (delay == 0) begin
          ack  = 1'b1;
          busy = 1'b0;
          if (we) begin
            dmem[dmem_index(addr)] = wdata;
            obs_addr.push_back(addr);
            obs_data.push_back(wdata);
            n_obs++;
          end else begin
            rdata = dmem[dmem_index(addr)];
          end
        end else begin
          delay--;
        end
      end
      i_wb_ack_data  = ack;
      i_wb_data_data = rdata;
    end
  end

  // compares every completed write with the model's store list in order
  initial begin
    forever begin
      wait (n_obs > n_checked);
      if (n_checked >= n_exp) begin
        report_failure("the DUT wrote more words than the program stores");
      end else begin
        check_word("o_wb_addr_data", exp_addr[n_checked], obs_addr[n_checked]);
        check_word("o_wb_data_data", exp_data[n_checked], obs_data[n_checked]);
        n_checked++;
      end
    end
  end

  initial begin
    wait (prog_len > 0);
    repeat (reset_cycles + cycles_per_inst * prog_len) @(posedge i_clk);
    report_failure("timeout, the last expected store never reached the data port");
  end

  initial begin
    i_arst_n       = 1'b0;
    i_inst         = `RV32I_NOP;
    i_ack_inst     = 1'b0;
    i_wb_ack_data  = 1'b0;
    i_wb_data_data = '0;
    n_obs          = 0;
    n_checked      = 0;
    n_exp          = 0;
    prog_len       = 0;
    lfsr_state     = 32'd78021;
    build_program();
    run_model();
    @(posedge i_clk);  // first falling edge after the clock starts
    @(negedge i_clk);
    check_flag("o_wb_cyc_data", 1'b0, o_wb_cyc_data);  // quiet data bus in reset
    check_flag("o_wb_stb_data", 1'b0, o_wb_stb_data);
    check_flag("o_stb_inst", 1'b1, o_stb_inst);
    check_word("o_iaddr", `RV32I_PC_RESET, o_iaddr);
    repeat (reset_cycles - 1) @(negedge i_clk);
    i_arst_n = 1'b1;
    wait (n_checked == n_exp);
    repeat (20) @(negedge i_clk);  // room for a duplicated store to show up
    check_count("store count", n_exp, n_obs);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
rv32i_pkg.sv
rv32i_stage_ifs.sv
rv32i_fetch.sv
rv32i_regfile.sv
rv32i_decode.sv
rv32i_execute.sv
rv32i_memory.sv
rv32i_core.sv
tb_rv32i_core.sv

// File: Bender.yml
package:
  name: rv32i_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv32i_pkg.sv
      - rv32i_stage_ifs.sv
      - rv32i_fetch.sv
      - rv32i_regfile.sv
      - rv32i_decode.sv
      - rv32i_execute.sv
      - rv32i_memory.sv
      - rv32i_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv32i_core.sv
